// File: common/rename_params.svh
// Rename stage sizing: register counts, tag widths and ROB depth
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Architectural registers x0 to x31
`define ARCH_REGS 32

// Physical register pool, twice the architectural count
`define PHYS_REGS 64

// Reorder buffer entries
`define ROB_DEPTH 8

// Tag and id widths, kept in step with the counts above
`define PTAG_W 6
`define ROB_ID_W 3

`endif

// File: common/inst_pkg.sv
// Instruction package: RV32I opcodes and the two field layouts of an instruction word
`default_nettype none

package inst_pkg;

    // Architectural register index
    typedef logic [4:0] areg_t;

    // Opcodes the rename stage knows about
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011
    } opcode_e;

    // R-type and I-type layout, rd in bits 11:7
    typedef struct packed {
        logic [6:0] funct7;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        areg_t      rd;
        logic [6:0] opcode;
    } reg_form_t;

    // S-type layout, immediate split around the sources
    typedef struct packed {
        logic [6:0] imm_hi;
        areg_t      rs2;
        areg_t      rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } store_form_t;

    // Same 32 bits, read either way
    typedef union packed {
        reg_form_t   r;
        store_form_t s;
    } inst_word_u;

endpackage

`default_nettype wire

// File: common/rename_pkg.sv
// Rename package: physical tag, ROB id and the dispatch entry handed to RS and ROB
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    // Physical register tag
    typedef logic [`PTAG_W-1:0] ptag_t;

    // Reorder buffer slot id
    typedef logic [`ROB_ID_W-1:0] rob_id_t;

    // One renamed instruction
    typedef struct packed {
        // PC of the instruction
        logic [31:0] pc;
        rob_id_t     rob_id;
        // Source tags, 0 when the source is unused
        ptag_t       ps1;
        ptag_t       ps2;
        // New destination tag and the mapping it replaces
        ptag_t       pd;
        ptag_t       old_pd;
        // Which fields carry meaning
        logic        rs1_used;
        logic        rs2_used;
        logic        rd_en;
        // Store marker, used for the commit stall
        logic        is_store;
    } dispatch_entry_t;

endpackage

`default_nettype wire

// File: common/rename_if.sv
// Rename interface between the dispatcher and the register alias table
`default_nettype none
`timescale 1ns/1ps

interface rename_if
    import inst_pkg::*;
    import rename_pkg::*;
();

    // Lookup and update request from the dispatcher
    areg_t arch_rs1;
    areg_t arch_rs2;
    areg_t arch_rd;
    ptag_t new_pd;
    // Write strobe, new_pd lands in arch_rd at the edge
    logic  update;

    // Combinational answers from the table
    ptag_t ps1;
    ptag_t ps2;
    ptag_t old_pd;

    modport ctrl (
        output arch_rs1, arch_rs2, arch_rd, new_pd, update,
        input  ps1, ps2, old_pd
    );

    modport rat (
        input  arch_rs1, arch_rs2, arch_rd, new_pd, update,
        output ps1, ps2, old_pd
    );

endinterface

`default_nettype wire

// File: dispatch/dispatch_ctrl.sv
// Dispatch control: decodes the queue head, issues pops and registers the dispatch entry
`default_nettype none
`timescale 1ns/1ps

module dispatch_ctrl
    import inst_pkg::*;
    import rename_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  inst_word_u      inst_word,
    input  logic [31:0]     inst_pc,
    input  logic            rs_full,
    input  logic            rob_full,
    input  rob_id_t         next_rob_id,
    input  ptag_t           free_pd,
    input  logic            free_empty,
    input  logic            store_commit,
    rename_if.ctrl          rn,
    output logic            pop,
    output logic            alloc,
    output dispatch_entry_t entry,
    output logic            entry_valid,
    output logic            stall_store
);

    typedef enum logic {RUN, STORE_WAIT} state_e;

    state_e state;
    state_e state_next;

    logic is_op;
    logic is_op_imm;
    logic is_load;
    logic is_store;
    logic rs1_used;
    logic rs2_used;
    logic rd_en;

    // Opcode decode
    assign is_op     = inst_word.r.opcode == OP;
    assign is_op_imm = inst_word.r.opcode == OP_IMM;
    assign is_load   = inst_word.r.opcode == LOAD;
    assign is_store  = inst_word.s.opcode == STORE;

    // Source and destination usage per opcode
    assign rs1_used = is_op | is_op_imm | is_load | is_store;
    assign rs2_used = is_op | is_store;
    // x0 as destination means nothing to rename
    assign rd_en    = (is_op | is_op_imm | is_load) && (inst_word.r.rd != areg_t'(0));

    // Take the head only when every consumer has room
    assign pop   = inst_valid && !rs_full && !rob_full && (state == RUN)
                   && (!free_empty || !rd_en);
    // Free list and RAT move only for a real destination
    assign alloc = pop && rd_en;

    // RAT lookups, rs1 and rs2 sit at the same bits in both layouts
    assign rn.arch_rs1 = inst_word.r.rs1;
    assign rn.arch_rs2 = inst_word.r.rs2;
    assign rn.arch_rd  = inst_word.r.rd;
    assign rn.new_pd   = free_pd;
    assign rn.update   = alloc;

    // Store holds dispatch until its commit comes back
    always_comb begin
        state_next = state;
        case (state)
            RUN:        if (pop && is_store) state_next = STORE_WAIT;
            STORE_WAIT: if (store_commit) state_next = RUN;
            default:    state_next = RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= RUN;
            entry_valid <= 1'b0;
        end else begin
            state       <= state_next;
            entry_valid <= pop;
        end
    end

    assign stall_store = state == STORE_WAIT;

    // Entry payload, captured in the pop cycle
    always_ff @(posedge clk) begin
        if (pop) begin
            entry.pc       <= inst_pc;
            entry.rob_id   <= next_rob_id;
            entry.ps1      <= rs1_used ? rn.ps1 : '0;
            entry.ps2      <= rs2_used ? rn.ps2 : '0;
            entry.pd       <= rd_en ? free_pd : '0;
            entry.old_pd   <= rd_en ? rn.old_pd : '0;
            entry.rs1_used <= rs1_used;
            entry.rs2_used <= rs2_used;
            entry.rd_en    <= rd_en;
            entry.is_store <= is_store;
        end
    end

    // No entry may follow a cycle spent waiting on a store
    a_no_entry_after_wait: assert property (@(posedge clk) disable iff (rst)
        $rose(entry_valid) |-> $past(state) == RUN);

endmodule

`default_nettype wire

// File: dispatch/rename_table.sv
// Register alias table: architectural to physical mapping with three read ports
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module rename_table
    import inst_pkg::*;
    import rename_pkg::*;
(
    input  logic clk,
    input  logic rst,
    rename_if.rat rn
);

    // One physical tag per architectural register
    ptag_t map [`ARCH_REGS];

    logic wr_en;

    // Reads see the mapping before this cycle's write
    assign rn.ps1    = map[rn.arch_rs1];
    assign rn.ps2    = map[rn.arch_rs2];
    // Mapping that the new destination displaces
    assign rn.old_pd = map[rn.arch_rd];

    // x0 stays pinned to tag 0
    assign wr_en = rn.update && (rn.arch_rd != areg_t'(0));

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, register i lives in tag i
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map[i] <= ptag_t'(i);
            end
        end else if (wr_en) begin
            map[rn.arch_rd] <= rn.new_pd;
        end
    end

    // Dispatcher must never ask to rename x0
    a_no_x0_update: assert property (@(posedge clk) disable iff (rst)
        rn.update |-> rn.arch_rd != areg_t'(0));

endmodule

`default_nettype wire

// File: dispatch/free_list.sv
// Free list: circular buffer of unused physical tags, popped on rename and refilled on release
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module free_list
    import rename_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  alloc,
    output ptag_t free_pd,
    output logic  free_empty,
    input  logic  release_en,
    input  ptag_t release_pd
);

    // Tags above the architectural range start out free
    localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    ptag_t            slots [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;
    logic             full;

    // Show-ahead head tag
    assign free_pd    = slots[head];
    assign free_empty = count == '0;
    assign full       = count == (PTR_W + 1)'(DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            // Buffer starts full, so tail has wrapped onto head
            tail  <= '0;
            count <= (PTR_W + 1)'(DEPTH);
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= ptag_t'(`ARCH_REGS + i);
            end
        end else begin
            if (alloc) begin
                head <= head + 1'b1;
            end
            if (release_en) begin
                slots[tail] <= release_pd;
                tail        <= tail + 1'b1;
            end
            // Pop and push together leave the count alone
            case ({alloc, release_en})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_alloc_empty: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !free_empty);

    a_no_release_full: assert property (@(posedge clk) disable iff (rst)
        release_en |-> !full);

endmodule

`default_nettype wire

// File: logic/rob_id_counter.sv
// ROB id allocator: hands out ids in order and tracks occupancy for the full flag
`default_nettype none
`timescale 1ns/1ps

`include "rename_params.svh"

module rob_id_counter
    import rename_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    alloc,
    input  logic    retire,
    output rob_id_t next_rob_id,
    output logic    rob_full
);

    // One extra bit so a full ROB is distinct from an empty one
    localparam int OCC_W = $clog2(`ROB_DEPTH) + 1;

    rob_id_t          tail;
    logic [OCC_W-1:0] occupancy;

    assign next_rob_id = tail;
    assign rob_full    = occupancy == OCC_W'(`ROB_DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            tail      <= '0;
            occupancy <= '0;
        end else begin
            // Id wraps modulo the ROB depth
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            case ({alloc, retire})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !rob_full);

    a_no_retire_empty: assert property (@(posedge clk) disable iff (rst)
        retire |-> occupancy != '0);

endmodule

`default_nettype wire

// File: logic/rename_dispatch_top.sv
// Rename and dispatch top: ties dispatcher, RAT, free list and ROB id allocator together
`default_nettype none
`timescale 1ns/1ps

module rename_dispatch_top
    import inst_pkg::*;
    import rename_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid,
    input  logic [31:0] inst_word,
    input  logic [31:0] inst_pc,
    input  logic        rs_full,
    input  logic        retire,
    input  logic        release_en,
    input  ptag_t       release_pd,
    input  logic        store_commit,
    output logic        pop,
    output logic        entry_valid,
    output logic [31:0] entry_pc,
    output rob_id_t     entry_rob_id,
    output ptag_t       entry_ps1,
    output ptag_t       entry_ps2,
    output ptag_t       entry_pd,
    output ptag_t       entry_old_pd,
    output logic        entry_rs1_used,
    output logic        entry_rs2_used,
    output logic        entry_rd_en,
    output logic        entry_is_store,
    output logic        stall_store
);

    ptag_t           free_pd;
    logic            free_empty;
    logic            tag_alloc;
    rob_id_t         next_rob_id;
    logic            rob_full;
    dispatch_entry_t entry;

    rename_if rn_if ();

    dispatch_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .inst_valid   (inst_valid),
        .inst_word    (inst_word_u'(inst_word)),
        .inst_pc      (inst_pc),
        .rs_full      (rs_full),
        .rob_full     (rob_full),
        .next_rob_id  (next_rob_id),
        .free_pd      (free_pd),
        .free_empty   (free_empty),
        .store_commit (store_commit),
        .rn           (rn_if.ctrl),
        .pop          (pop),
        .alloc        (tag_alloc),
        .entry        (entry),
        .entry_valid  (entry_valid),
        .stall_store  (stall_store)
    );

    rename_table u_rat (
        .clk (clk),
        .rst (rst),
        .rn  (rn_if.rat)
    );

    free_list u_free (
        .clk        (clk),
        .rst        (rst),
        .alloc      (tag_alloc),
        .free_pd    (free_pd),
        .free_empty (free_empty),
        .release_en (release_en),
        .release_pd (release_pd)
    );

    // Every dispatched instruction takes a ROB slot, destination or not
    rob_id_counter u_rob_id (
        .clk         (clk),
        .rst         (rst),
        .alloc       (pop),
        .retire      (retire),
        .next_rob_id (next_rob_id),
        .rob_full    (rob_full)
    );

    // Entry fields out as flat ports
    assign entry_pc       = entry.pc;
    assign entry_rob_id   = entry.rob_id;
    assign entry_ps1      = entry.ps1;
    assign entry_ps2      = entry.ps2;
    assign entry_pd       = entry.pd;
    assign entry_old_pd   = entry.old_pd;
    assign entry_rs1_used = entry.rs1_used;
    assign entry_rs2_used = entry.rs2_used;
    assign entry_rd_en    = entry.rd_en;
    assign entry_is_store = entry.is_store;

endmodule

`default_nettype wire

// File: bench/tb_rename_dispatch.sv
// Rename and dispatch testbench: replays pattern vectors and checks each dispatch entry
`default_nettype none
`timescale 1ns/1ps

module tb_rename_dispatch;

    localparam int NT = 14;
    localparam int NF = 15;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst_word;
    logic [31:0] inst_pc;
    logic        rs_full;
    logic        retire;
    logic        release_en;
    logic [5:0]  release_pd;
    logic        store_commit;
    logic        pop;
    logic        entry_valid;
    logic [31:0] entry_pc;
    logic [2:0]  entry_rob_id;
    logic [5:0]  entry_ps1;
    logic [5:0]  entry_ps2;
    logic [5:0]  entry_pd;
    logic [5:0]  entry_old_pd;
    logic        entry_rs1_used;
    logic        entry_rs2_used;
    logic        entry_rd_en;
    logic        entry_is_store;
    logic        stall_store;

    // Vectors, NF words per test
    logic [31:0] pat [NT*NF];
    // Reference model of RAT, free list and ROB tail
    int sh_rat [32];
    int sh_free [$];
    int sh_rob;
    int bad;
    int passed;
    int failed;
    int cycles = 0;
    int limit;
    int total_reps;
    string names [7] = '{"rob_id", "ps1", "ps2", "pd", "old_pd", "rd_en", "is_store"};

    rename_dispatch_top dut0 (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst_word(inst_word),
        .inst_pc(inst_pc), .rs_full(rs_full), .retire(retire), .release_en(release_en),
        .release_pd(release_pd), .store_commit(store_commit), .pop(pop),
        .entry_valid(entry_valid), .entry_pc(entry_pc), .entry_rob_id(entry_rob_id),
        .entry_ps1(entry_ps1), .entry_ps2(entry_ps2), .entry_pd(entry_pd),
        .entry_old_pd(entry_old_pd), .entry_rs1_used(entry_rs1_used),
        .entry_rs2_used(entry_rs2_used), .entry_rd_en(entry_rd_en),
        .entry_is_store(entry_is_store), .stall_store(stall_store)
    );

    always #4 clk = ~clk;

    // Run guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Instruction waits at the queue head while something holds pop low
    task automatic hold_window(input int t, input bit want_stall);
        repeat (4) begin
            @(negedge clk);
            if (pop || entry_valid) begin
                $display("t%0d: instruction left the queue while it should be held", t);
                bad++;
            end
            if (want_stall && !stall_store) begin
                $display("t%0d: stall_store is low while a store waits for commit", t);
                bad++;
            end
        end
    endtask

    task automatic dispatch_one(input int t, input bit last);
        int          base;
        logic [31:0] w;
        logic [6:0]  op;
        bit          u1;
        bit          u2;
        bit          rde;
        bit          st;
        int          mdl [7];
        int          exp [7];
        int          act [7];
        base = t * NF;
        w    = pat[base];
        op   = w[6:0];
        // Usage rules per opcode
        st   = op == 7'h23;
        u1   = op == 7'h33 || op == 7'h13 || op == 7'h03 || st;
        u2   = op == 7'h33 || st;
        rde  = (op == 7'h33 || op == 7'h13 || op == 7'h03) && w[11:7] != 5'd0;
        mdl[0] = sh_rob;
        mdl[1] = u1 ? sh_rat[w[19:15]] : 0;
        mdl[2] = u2 ? sh_rat[w[24:20]] : 0;
        mdl[3] = rde ? sh_free[0] : 0;
        mdl[4] = rde ? sh_rat[w[11:7]] : 0;
        mdl[5] = int'(rde);
        mdl[6] = int'(st);
        @(posedge clk);
        inst_valid <= 1'b1;
        @(negedge clk);
        while (!pop) @(negedge clk);
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        if (!entry_valid) begin
            $display("t%0d: no entry_valid in the cycle after the pop", t);
            bad++;
        end else begin
            act = '{int'(entry_rob_id), int'(entry_ps1), int'(entry_ps2), int'(entry_pd),
                    int'(entry_old_pd), int'(entry_rd_en), int'(entry_is_store)};
            for (int i = 0; i < 7; i++) begin
                exp[i] = last ? int'(pat[base + 8 + i]) : mdl[i];
                if (last && exp[i] != mdl[i]) begin
                    $display("t%0d: pattern line disagrees with reference model on %s",
                             t, names[i]);
                    bad++;
                end
                if (exp[i] != act[i]) begin
                    $display("error t%0d %s: expected 0x%0h actual 0x%0h",
                             t, names[i], exp[i], act[i]);
                    bad++;
                end
            end
            if (entry_pc != pat[base + 1]) begin
                $display("error t%0d pc: expected 0x%0h actual 0x%0h",
                         t, pat[base + 1], entry_pc);
                bad++;
            end
            if (entry_rs1_used != u1 || entry_rs2_used != u2) begin
                $display("error t%0d rs_used: expected %0d%0d actual %0d%0d",
                         t, u1, u2, entry_rs1_used, entry_rs2_used);
                bad++;
            end
        end
        // Advance the model
        if (rde) begin
            sh_rat[w[11:7]] = sh_free.pop_front();
        end
        sh_rob = (sh_rob + 1) % 8;
        // Keep the ROB draining between repeats
        if (!last) begin
            @(posedge clk);
            retire <= 1'b1;
            @(posedge clk);
            retire <= 1'b0;
        end
    endtask

    initial begin
        int base;
        int reps;
        int n_ret;
        clk = 1'b0;
        rst = 1'b1;
        inst_valid = 1'b0;
        inst_word = '0;
        inst_pc = '0;
        rs_full = 1'b0;
        retire = 1'b0;
        release_en = 1'b0;
        release_pd = '0;
        store_commit = 1'b0;
        passed = 0;
        failed = 0;
        total_reps = 0;
        $readmemh("bench/rename_patterns.txt", pat);
        for (int t = 0; t < NT; t++) begin
            total_reps += int'(pat[t * NF + 7]);
        end
        limit = 20 * total_reps + 100;
        for (int i = 0; i < 32; i++) begin
            sh_rat[i] = i;
            sh_free.push_back(32 + i);
        end
        sh_rob = 0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int t = 0; t < NT; t++) begin
            base  = t * NF;
            reps  = int'(pat[base + 7]);
            n_ret = int'(pat[base + 3]);
            bad   = 0;
            @(posedge clk);
            inst_word <= pat[base];
            inst_pc   <= pat[base + 1];
            if (pat[base + 4][0]) begin
                release_en <= 1'b1;
                release_pd <= pat[base + 5][5:0];
                sh_free.push_back(int'(pat[base + 5]));
                @(posedge clk);
                release_en <= 1'b0;
            end
            // Blocked phase, then lift whatever held the pop
            if (pat[base + 2][0] || pat[base + 6][0] || n_ret > 0) begin
                rs_full    <= pat[base + 2][0];
                inst_valid <= 1'b1;
                hold_window(t, pat[base + 6][0]);
                @(posedge clk);
                inst_valid   <= 1'b0;
                rs_full      <= 1'b0;
                store_commit <= pat[base + 6][0];
                @(posedge clk);
                store_commit <= 1'b0;
                if (n_ret > 0) begin
                    retire <= 1'b1;
                    repeat (n_ret) @(posedge clk);
                    retire <= 1'b0;
                end
            end
            for (int r = 0; r < reps; r++) begin
                dispatch_one(t, r == reps - 1);
            end
            if (bad == 0) passed++;
            else failed++;
            $display("t%0d finished with %0d errors", t, bad);
        end
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/rename_patterns.txt
// word pc rs_full retire release release_pd store_commit reps
// then expected rob_id ps1 ps2 pd old_pd rd_en is_store
002081B3 00001000 0 0 0 00 0 1  0 01 02 20 03 1 0
00318233 00001004 0 0 0 00 0 1  1 20 20 21 04 1 0
00520193 00001008 0 0 0 00 0 1  2 21 00 22 20 1 0
0001A283 0000100C 0 0 0 00 0 1  3 22 00 23 05 1 0
00208033 00001010 0 0 0 00 0 1  4 01 02 00 00 0 0
12345337 00001014 0 0 0 00 0 1  5 00 00 00 00 0 0
0050A4A3 00001018 0 0 0 00 0 1  6 01 23 00 00 0 1
00428333 0000101C 0 0 0 00 1 1  7 23 21 24 06 1 0
003303B3 00001020 0 2 0 00 0 1  0 24 22 25 07 1 0
00138433 00001024 1 0 0 00 0 1  1 25 01 26 08 1 0
00148493 00001028 0 8 1 03 0 19 2 3E 00 3F 3E 1 0
00848533 0000102C 0 0 1 04 0 1  3 3F 26 03 0A 1 0
00A505B3 00001030 0 0 0 00 0 1  4 03 03 04 0B 1 0
00158033 00001034 0 0 0 00 0 1  5 04 01 00 00 0 0

// File: tb.f
+incdir+common
common/inst_pkg.sv
common/rename_pkg.sv
common/rename_if.sv
dispatch/dispatch_ctrl.sv
dispatch/rename_table.sv
dispatch/free_list.sv
logic/rob_id_counter.sv
logic/rename_dispatch_top.sv
bench/tb_rename_dispatch.sv

// File: Makefile
TOP = tb_rename_dispatch

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
